/* logic/vm16_pkg.sv */
// ******************************
// vm16 widths, encodings and memory map
// imported by the RTL and the testbench
// ******************************
package vm16_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_SEL_W = 3;
    localparam int NUM_REGS  = 8;

    // memory map: data addresses below the scratch depth stay local,
    // everything else becomes an APB transfer
    localparam int DEFAULT_IMEM_DEPTH    = 64;
    localparam int DEFAULT_SCRATCH_DEPTH = 64;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [WORD_W-1:0]    instr_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;

    // major opcodes, bits 15..11 of the instruction
    typedef enum logic [4:0] {
        OP_NOP     = 5'h00,
        OP_LW      = 5'h01,
        OP_SW      = 5'h02,
        OP_BIT     = 5'h03,
        OP_MOV     = 5'h04,
        OP_MOVI    = 5'h05,
        OP_ARITH_U = 5'h07,
        OP_HALT    = 5'h0c
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_NOP    = 4'h0,
        ALU_PASS_B = 4'h1,
        ALU_OR     = 4'h2,
        ALU_XOR    = 4'h3,
        ALU_AND    = 4'h4,
        ALU_NOT    = 4'h5,
        ALU_LSHFT  = 4'h6,
        ALU_RSHFT  = 4'h7,
        ALU_ADD    = 4'h8,
        ALU_SUB    = 4'h9
    } alu_op_t;

    // sub-functions in simm5 for OP_BIT
    localparam logic [4:0] FN_BIT_OR    = 5'h00;
    localparam logic [4:0] FN_BIT_XOR   = 5'h01;
    localparam logic [4:0] FN_BIT_AND   = 5'h02;
    localparam logic [4:0] FN_BIT_NOT   = 5'h03;
    localparam logic [4:0] FN_BIT_LSHFT = 5'h04;
    localparam logic [4:0] FN_BIT_RSHFT = 5'h05;

    // sub-functions in simm5 for OP_ARITH_U
    // add-immediate only needs bit 4 clear, imm4 sits in the low bits
    localparam logic [4:0] FN_ARITH_UADDI = 5'b00000;
    localparam logic [4:0] FN_ARITH_USUB  = 5'b10000;
    localparam logic [4:0] FN_ARITH_UADD  = 5'b11111;

endpackage

/* logic/vm16_decoder.sv */
// ******************************
// instruction field split and control decode
// ******************************
`timescale 1ns/1ps

module vm16_decoder (
    input  vm16_pkg::instr_t   instr,
    output vm16_pkg::reg_sel_t rd,
    output vm16_pkg::reg_sel_t ra,
    output logic [7:0]         imm8,
    output logic [3:0]         imm4,
    output logic [4:0]         simm5,
    output vm16_pkg::alu_op_t  alu_op,
    output logic               has_imm4,
    output logic               has_imm8,
    output logic               has_we,
    output logic               has_mem,
    output logic               has_mem_we,
    output logic               halt
);
    import vm16_pkg::*;

    opcode_t opcode;

    assign opcode = opcode_t'(instr[15:11]);
    assign rd     = instr[10:8];
    assign ra     = instr[7:5];
    assign imm8   = instr[7:0];
    assign simm5  = instr[4:0];
    assign imm4   = instr[3:0];

    always_comb begin
        alu_op = ALU_NOP;
        case (opcode)
            // moves and memory ops all want operand b unchanged
            OP_MOV, OP_MOVI, OP_LW, OP_SW: alu_op = ALU_PASS_B;
            OP_BIT: begin
                case (simm5)
                    FN_BIT_OR:    alu_op = ALU_OR;
                    FN_BIT_XOR:   alu_op = ALU_XOR;
                    FN_BIT_AND:   alu_op = ALU_AND;
                    FN_BIT_NOT:   alu_op = ALU_NOT;
                    FN_BIT_LSHFT: alu_op = ALU_LSHFT;
                    FN_BIT_RSHFT: alu_op = ALU_RSHFT;
                    default:      alu_op = ALU_NOP;
                endcase
            end
            OP_ARITH_U: begin
                if (simm5[4] == FN_ARITH_UADDI[4]) begin
                    alu_op = ALU_ADD;
                end else if (simm5 == FN_ARITH_UADD) begin
                    alu_op = ALU_ADD;
                end else if (simm5 == FN_ARITH_USUB) begin
                    alu_op = ALU_SUB;
                end
            end
            default: alu_op = ALU_NOP;
        endcase
    end

    // unknown sub-functions decode to NOP and must not write rd
    always_comb begin
        case (opcode)
            OP_MOV, OP_MOVI, OP_LW: has_we = 1'b1;
            OP_BIT, OP_ARITH_U:     has_we = (alu_op != ALU_NOP);
            default:                has_we = 1'b0;
        endcase
    end

    assign has_imm4   = (opcode == OP_ARITH_U) && (simm5[4] == FN_ARITH_UADDI[4]);
    assign has_imm8   = (opcode == OP_MOVI);
    assign has_mem    = (opcode == OP_LW) || (opcode == OP_SW);
    assign has_mem_we = (opcode == OP_SW);
    assign halt       = (opcode == OP_HALT);

endmodule

/* logic/vm16_alu.sv */
// ******************************
// combinational ALU, unsigned only
// ******************************
`timescale 1ns/1ps

module vm16_alu (
    input  vm16_pkg::alu_op_t op,
    input  vm16_pkg::word_t   a,
    input  vm16_pkg::word_t   b,
    output vm16_pkg::word_t   c
);
    import vm16_pkg::*;

    always_comb begin
        case (op)
            // moves, and the address operand of LW/SW
            ALU_PASS_B: c = b;
            ALU_OR:     c = a | b;
            ALU_XOR:    c = a ^ b;
            ALU_AND:    c = a & b;
            ALU_NOT:    c = ~b;
            // shift amount is the whole of b
            ALU_LSHFT:  c = a << b;
            ALU_RSHFT:  c = a >> b;
            ALU_ADD:    c = a + b;
            ALU_SUB:    c = a - b;
            default:    c = '0;
        endcase
    end

endmodule

/* logic/vm16_regfile.sv */
// ******************************
// 8 x 16 register file
// one async read port, one sync write port
// ******************************
`timescale 1ns/1ps

module vm16_regfile (
    input  logic               clk,
    input  logic               reset,
    input  vm16_pkg::reg_sel_t rs,
    output vm16_pkg::word_t    rd,
    input  logic               we,
    input  vm16_pkg::reg_sel_t ws,
    input  vm16_pkg::word_t    wd
);
    import vm16_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[ws] <= wd;
        end
    end

    assign rd = regs[rs];

endmodule

/* logic/vm16_bram.sv */
// ******************************
// single-port sync RAM
// output register holds its value on writes
// ******************************
`timescale 1ns/1ps

module vm16_bram #(
    parameter int depth = vm16_pkg::DEFAULT_SCRATCH_DEPTH
) (
    input  logic                     clk,
    input  logic [$clog2(depth)-1:0] addr,
    input  vm16_pkg::word_t          wdata,
    input  logic                     we,
    output vm16_pkg::word_t          rdata
);
    import vm16_pkg::*;

    word_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

/* logic/vm16_mmu.sv */
// ******************************
// data address decode: scratch RAM below
// scratch_depth, APB master above it
// ******************************
`timescale 1ns/1ps

module vm16_mmu #(
    parameter int scratch_depth = vm16_pkg::DEFAULT_SCRATCH_DEPTH
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            req,
    output logic            busy,
    input  vm16_pkg::word_t addr,
    input  vm16_pkg::word_t wdata,
    input  logic            we,
    output vm16_pkg::word_t rdata,
    output vm16_pkg::word_t paddr,
    output logic            pwrite,
    output logic            psel,
    output logic            penable,
    output vm16_pkg::word_t pwdata,
    input  vm16_pkg::word_t prdata,
    input  logic            pready
);
    import vm16_pkg::*;

    localparam int scratch_aw = $clog2(scratch_depth);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } apb_state_t;

    apb_state_t state;
    logic       is_scratch;
    logic       scratch_we;
    logic       apb_start;
    logic       apb_done;
    logic       last_scratch;
    word_t      scratch_rdata;
    word_t      apb_rdata;

    assign is_scratch = (addr < word_t'(scratch_depth));
    assign scratch_we = req && is_scratch && we;
    assign apb_start  = (state == ST_IDLE) && req && !is_scratch;
    assign apb_done   = (state == ST_ACCESS) && pready;

    // busy drops in the last cycle of the access;
    // rdata is valid from the following cycle on
    assign busy  = req || (state == ST_SETUP) || ((state == ST_ACCESS) && !pready);
    assign rdata = last_scratch ? scratch_rdata : apb_rdata;

    // remember which side served the request
    always_ff @(posedge clk) begin
        if (reset) begin
            last_scratch <= 1'b0;
        end else if (req) begin
            last_scratch <= is_scratch;
        end
    end

    // APB master: idle -> setup -> access (waits on pready)
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            psel    <= 1'b0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (apb_start) begin
                        psel   <= 1'b1;
                        pwrite <= we;
                        state  <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    penable <= 1'b1;
                    state   <= ST_ACCESS;
                end
                ST_ACCESS: begin
                    if (pready) begin
                        psel    <= 1'b0;
                        penable <= 1'b0;
                        pwrite  <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // address and data held for the whole transfer
    always_ff @(posedge clk) begin
        if (apb_start) begin
            paddr  <= addr;
            pwdata <= wdata;
        end
        if (apb_done) begin
            apb_rdata <= prdata;
        end
    end

    vm16_bram #(
        .depth (scratch_depth)
    ) scratch (
        .clk   (clk),
        .addr  (addr[scratch_aw-1:0]),
        .wdata (wdata),
        .we    (scratch_we),
        .rdata (scratch_rdata)
    );

endmodule

/* logic/vm16_core.sv */
// ******************************
// vm16 multi-cycle core, top level
// imem is loaded through the load port during reset
// ******************************
`timescale 1ns/1ps

module vm16_core #(
    parameter int imem_depth    = vm16_pkg::DEFAULT_IMEM_DEPTH,
    parameter int scratch_depth = vm16_pkg::DEFAULT_SCRATCH_DEPTH
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          imem_we,
    input  logic [$clog2(imem_depth)-1:0] imem_addr,
    input  vm16_pkg::instr_t              imem_data,
    output vm16_pkg::word_t               paddr,
    output logic                          pwrite,
    output logic                          psel,
    output logic                          penable,
    output vm16_pkg::word_t               pwdata,
    input  vm16_pkg::word_t               prdata,
    input  logic                          pready,
    output logic                          halted
);
    import vm16_pkg::*;

    localparam int imem_aw = $clog2(imem_depth);

    typedef enum logic [2:0] {
        S_FETCH,
        S_OP1,
        S_OP2,
        S_MEM,
        S_WB,
        S_HALTED
    } cpu_state_t;

    cpu_state_t         state;
    logic [imem_aw-1:0] pc;
    logic [imem_aw-1:0] imem_rd_addr;
    logic               imem_load;
    word_t              imem_rdata;
    instr_t             instr;
    reg_sel_t           dec_rd;
    reg_sel_t           dec_ra;
    logic [7:0]         imm8;
    logic [3:0]         imm4;
    logic [4:0]         simm5;
    alu_op_t            alu_op;
    logic               has_imm4;
    logic               has_imm8;
    logic               has_we;
    logic               has_mem;
    logic               has_mem_we;
    logic               halt;
    reg_sel_t           rs;
    word_t              reg_rdata;
    word_t              op_a;
    word_t              op_b;
    word_t              alu_c;
    word_t              mem_addr;
    word_t              mem_rdata;
    word_t              wb_data;
    logic               reg_we;
    logic               mem_req;
    logic               mem_busy;

    // load port only acts under reset; it must go quiet one cycle
    // before reset drops so the first fetch reads word 0
    assign imem_load    = imem_we && reset;
    assign imem_rd_addr = imem_load ? imem_addr : pc;

    // single read port: rd in operand 1, ra in operand 2
    assign rs       = (state == S_OP2) ? dec_ra : dec_rd;
    assign mem_addr = alu_c + {{11{simm5[4]}}, simm5};
    assign wb_data  = has_mem ? mem_rdata : alu_c;
    assign reg_we   = has_we && (state == S_WB);
    assign halted   = (state == S_HALTED);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_FETCH;
            pc      <= '0;
            instr   <= '0;
            mem_req <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    instr <= imem_rdata;
                    state <= S_OP1;
                end
                S_OP1: begin
                    state <= halt ? S_HALTED : S_OP2;
                end
                S_OP2: begin
                    // pc sticks at the last word
                    if (pc != imem_aw'(imem_depth - 1)) begin
                        pc <= pc + 1'b1;
                    end
                    if (has_mem) begin
                        mem_req <= 1'b1;
                        state   <= S_MEM;
                    end else begin
                        state <= S_WB;
                    end
                end
                S_MEM: begin
                    mem_req <= 1'b0;
                    if (!mem_busy) begin
                        state <= S_WB;
                    end
                end
                S_WB:     state <= S_FETCH;
                S_HALTED: state <= S_HALTED;
                default:  state <= S_FETCH;
            endcase
        end
    end

    // operand latches
    always_ff @(posedge clk) begin
        if (state == S_OP1) begin
            op_a <= reg_rdata;
        end
        if (state == S_OP2) begin
            if (has_imm8) begin
                op_b <= {8'h00, imm8};
            end else if (has_imm4) begin
                op_b <= reg_rdata + {12'h000, imm4};
            end else begin
                op_b <= reg_rdata;
            end
        end
    end

    vm16_bram #(
        .depth (imem_depth)
    ) imem (
        .clk   (clk),
        .addr  (imem_rd_addr),
        .wdata (imem_data),
        .we    (imem_load),
        .rdata (imem_rdata)
    );

    vm16_decoder decoder (
        .instr      (instr),
        .rd         (dec_rd),
        .ra         (dec_ra),
        .imm8       (imm8),
        .imm4       (imm4),
        .simm5      (simm5),
        .alu_op     (alu_op),
        .has_imm4   (has_imm4),
        .has_imm8   (has_imm8),
        .has_we     (has_we),
        .has_mem    (has_mem),
        .has_mem_we (has_mem_we),
        .halt       (halt)
    );

    vm16_regfile regfile (
        .clk   (clk),
        .reset (reset),
        .rs    (rs),
        .rd    (reg_rdata),
        .we    (reg_we),
        .ws    (dec_rd),
        .wd    (wb_data)
    );

    vm16_alu alu (
        .op (alu_op),
        .a  (op_a),
        .b  (op_b),
        .c  (alu_c)
    );

    // store data is the rd operand
    vm16_mmu #(
        .scratch_depth (scratch_depth)
    ) mmu (
        .clk     (clk),
        .reset   (reset),
        .req     (mem_req),
        .busy    (mem_busy),
        .addr    (mem_addr),
        .wdata   (op_a),
        .we      (has_mem_we),
        .rdata   (mem_rdata),
        .paddr   (paddr),
        .pwrite  (pwrite),
        .psel    (psel),
        .penable (penable),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

endmodule

/* tb/vm16_iss.svh */
// ******************************
// instruction-set model of vm16, included
// in the testbench module to predict APB traffic
// ******************************

// value the APB slave model returns on a read
function automatic word_t apb_read_value(word_t addr);
    return addr ^ read_xor;
endfunction

// shifts by 16 or more clear the word
function automatic word_t shift_word(word_t a, word_t amount, bit left);
    if (amount > 16'd15) begin
        return '0;
    end
    return left ? (a << amount[3:0]) : (a >> amount[3:0]);
endfunction

// runs prog from zeroed registers up to HALT and fills the expected
// APB write list and read-address list, both in program order
function automatic void predict_program();
    word_t      regs [NUM_REGS];
    word_t      scratch [scratch_depth];
    instr_t     ins;
    reg_sel_t   rd;
    reg_sel_t   ra;
    logic [4:0] fn;
    word_t      ea;
    exp_wr_addr.delete();
    exp_wr_data.delete();
    exp_rd_addr.delete();
    foreach (regs[i]) regs[i] = '0;
    foreach (scratch[i]) scratch[i] = '0;
    for (int pc = 0; pc < prog_len; pc++) begin
        ins = prog[pc];
        rd  = ins[10:8];
        ra  = ins[7:5];
        fn  = ins[4:0];
        // effective address of LW/SW: ra plus signed 5-bit offset
        ea  = regs[ra] + {{11{fn[4]}}, fn};
        case (opcode_t'(ins[15:11]))
            OP_HALT: return;
            OP_MOVI: regs[rd] = {8'h00, ins[7:0]};
            OP_MOV:  regs[rd] = regs[ra];
            OP_ARITH_U: begin
                if (!fn[4]) begin
                    regs[rd] = regs[rd] + regs[ra] + {12'h000, ins[3:0]};
                end else if (fn == FN_ARITH_UADD) begin
                    regs[rd] = regs[rd] + regs[ra];
                end else if (fn == FN_ARITH_USUB) begin
                    regs[rd] = regs[rd] - regs[ra];
                end
            end
            OP_BIT: begin
                case (fn)
                    FN_BIT_OR:    regs[rd] = regs[rd] | regs[ra];
                    FN_BIT_XOR:   regs[rd] = regs[rd] ^ regs[ra];
                    FN_BIT_AND:   regs[rd] = regs[rd] & regs[ra];
                    FN_BIT_NOT:   regs[rd] = ~regs[ra];
                    FN_BIT_LSHFT: regs[rd] = shift_word(regs[rd], regs[ra], 1'b1);
                    FN_BIT_RSHFT: regs[rd] = shift_word(regs[rd], regs[ra], 1'b0);
                    default:      ;
                endcase
            end
            OP_LW: begin
                if (ea < word_t'(scratch_depth)) begin
                    regs[rd] = scratch[int'(ea)];
                end else begin
                    exp_rd_addr.push_back(ea);
                    regs[rd] = apb_read_value(ea);
                end
            end
            OP_SW: begin
                if (ea < word_t'(scratch_depth)) begin
                    scratch[int'(ea)] = regs[rd];
                end else begin
                    exp_wr_addr.push_back(ea);
                    exp_wr_data.push_back(regs[rd]);
                end
            end
            default: ;
        endcase
    end
endfunction

/* tb/tb_vm16_core.sv */
// ******************************
// random-program testbench for vm16_core
// with an APB slave model and transfer checks
// ******************************
`timescale 1ns/1ps

module tb_vm16_core;
    import vm16_pkg::*;

    localparam int    imem_depth    = DEFAULT_IMEM_DEPTH;
    localparam int    scratch_depth = DEFAULT_SCRATCH_DEPTH;
    localparam int    imem_aw       = $clog2(imem_depth);
    localparam int    max_waits     = 3;
    localparam int    cycles_per_op = 60;
    localparam word_t read_xor      = 16'hA5C3;

    logic               clk;
    logic               reset;
    logic               imem_we;
    logic [imem_aw-1:0] imem_addr;
    instr_t             imem_data;
    word_t              paddr;
    word_t              pwdata;
    logic               pwrite;
    logic               psel;
    logic               penable;
    word_t              prdata = '0;
    logic               pready = 1'b0;
    logic               halted;

    // program image and predicted transfers
    instr_t prog [imem_depth];
    int     prog_len;
    word_t  exp_wr_addr [$];
    word_t  exp_wr_data [$];
    word_t  exp_rd_addr [$];
    int     exp_total;

    int     seen;
    int     since_done;
    int     compared;
    int     data_errors;
    int     other_errors;
    int     cycles;
    int     cycle_limit;
    int     waits_left;
    logic   in_access = 1'b0;
    logic   prev_psel;
    logic   prev_penable;
    logic   prev_pwrite;
    logic   prev_halted;
    word_t  prev_paddr;
    word_t  prev_pwdata;

    `include "vm16_iss.svh"

    vm16_core #(
        .imem_depth    (imem_depth),
        .scratch_depth (scratch_depth)
    ) dut0 (
        .clk       (clk),
        .reset     (reset),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .paddr     (paddr),
        .pwrite    (pwrite),
        .psel      (psel),
        .penable   (penable),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_value(string name, word_t expected, word_t observed);
        $display("ERROR %0t: %s expected %h observed %h", $time, name, expected, observed);
        data_errors++;
    endtask

    task automatic report_failure(string what);
        $display("%0t: %s", $time, what);
        other_errors++;
    endtask

    task automatic print_counts();
        $display("errors: %0d data, %0d other; %0d transfers compared",
                 data_errors, other_errors, compared);
    endtask

    function automatic instr_t rr_instr(opcode_t op, reg_sel_t rd, reg_sel_t ra,
                                        logic [4:0] fn);
        return {op, rd, ra, fn};
    endfunction

    function automatic instr_t imm_instr(opcode_t op, reg_sel_t rd, logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    function automatic void append(instr_t ins);
        prog[prog_len] = ins;
        prog_len++;
    endfunction

    function automatic void fill_regs();
        for (int r = 0; r < 7; r++) begin
            append(imm_instr(OP_MOVI, reg_sel_t'(r), 8'($urandom)));
        end
    endfunction

    // r7 holds the APB base of at least 80 so base + offset stays off the scratch
    function automatic void store_regs();
        append(imm_instr(OP_MOVI, 3'd7, 8'($urandom_range(255, 80))));
        for (int r = 0; r < NUM_REGS; r++) begin
            append(rr_instr(OP_SW, reg_sel_t'(r), 3'd7, 5'($urandom)));
        end
        append(rr_instr(OP_HALT, 3'd0, 3'd0, 5'd0));
    endfunction

    function automatic void build_arith_program(bit fill);
        reg_sel_t rd;
        reg_sel_t ra;
        prog_len = 0;
        if (fill) begin
            fill_regs();
        end
        repeat (12) begin
            rd = reg_sel_t'($urandom_range(6, 0));
            ra = reg_sel_t'($urandom_range(6, 0));
            case ($urandom_range(3, 0))
                0: append(rr_instr(OP_MOV, rd, ra, 5'd0));
                1: append(rr_instr(OP_ARITH_U, rd, ra, FN_ARITH_UADD));
                2: append(rr_instr(OP_ARITH_U, rd, ra, {1'b0, 4'($urandom)}));
                default: append(rr_instr(OP_ARITH_U, rd, ra, FN_ARITH_USUB));
            endcase
        end
        store_regs();
    endfunction

    function automatic void build_bitwise_program();
        reg_sel_t   rd;
        reg_sel_t   ra;
        logic [4:0] fn;
        prog_len = 0;
        fill_regs();
        repeat (10) begin
            rd = reg_sel_t'($urandom_range(6, 0));
            ra = reg_sel_t'($urandom_range(6, 0));
            fn = 5'($urandom_range(5, 0));
            // small shift amounts keep most shift results nonzero
            if (fn == FN_BIT_LSHFT || fn == FN_BIT_RSHFT) begin
                append(imm_instr(OP_MOVI, ra, 8'($urandom_range(17, 0))));
            end
            append(rr_instr(OP_BIT, rd, ra, fn));
        end
        store_regs();
    endfunction

    function automatic void build_scratch_program();
        logic [4:0] off;
        prog_len = 0;
        repeat (3) begin
            off = 5'($urandom);
            // 16-bit value in r1 built from two bytes
            append(imm_instr(OP_MOVI, 3'd1, 8'($urandom)));
            append(imm_instr(OP_MOVI, 3'd4, 8'd8));
            append(rr_instr(OP_BIT, 3'd1, 3'd4, FN_BIT_LSHFT));
            append(imm_instr(OP_MOVI, 3'd5, 8'($urandom)));
            append(rr_instr(OP_BIT, 3'd1, 3'd5, FN_BIT_OR));
            append(imm_instr(OP_MOVI, 3'd2, 8'($urandom_range(47, 16))));
            append(rr_instr(OP_SW, 3'd1, 3'd2, off));
            append(rr_instr(OP_LW, 3'd3, 3'd2, off));
            append(imm_instr(OP_MOVI, 3'd7, 8'($urandom_range(255, 80))));
            append(rr_instr(OP_SW, 3'd3, 3'd7, 5'($urandom)));
        end
        append(rr_instr(OP_HALT, 3'd0, 3'd0, 5'd0));
    endfunction

    function automatic void build_apb_load_program();
        prog_len = 0;
        append(imm_instr(OP_MOVI, 3'd7, 8'($urandom_range(255, 80))));
        for (int r = 0; r < 6; r++) begin
            append(rr_instr(OP_LW, reg_sel_t'(r), 3'd7, 5'($urandom)));
        end
        store_regs();
    endfunction

    // predicts the transfers and writes the program through the load port under reset
    task automatic load_program();
        predict_program();
        exp_total   = exp_wr_addr.size() + exp_rd_addr.size();
        cycle_limit = cycle_limit + cycles_per_op * prog_len;
        @(negedge clk);
        reset <= 1'b1;
        for (int i = 0; i < prog_len; i++) begin
            imem_we   <= 1'b1;
            imem_addr <= imem_aw'(i);
            imem_data <= prog[i];
            @(negedge clk);
        end
        imem_we <= 1'b0;
        // also reached while the previous program sits halted
        assert (!psel && !penable && !halted) else begin
            report_failure("psel, penable or halted high while reset is held");
        end
        repeat (16) @(negedge clk);
        reset <= 1'b0;
    endtask

    // a few cycles after halt to see psel stay low
    task automatic wait_for_halt();
        while (!halted) @(negedge clk);
        repeat (8) @(negedge clk);
    endtask

    task automatic reset_mid_program();
        while (!(seen >= 2 && psel)) @(negedge clk);
        reset <= 1'b1;
        @(negedge clk);
        assert (!psel && !penable) else begin
            report_failure("psel or penable still high after reset");
        end
    endtask

    // APB slave with 0 to max_waits wait cycles per transfer
    always @(negedge clk) begin : apb_slave
        int waits;
        if (reset || !(psel && penable)) begin
            in_access <= 1'b0;
            pready    <= 1'b0;
        end else begin
            waits      = in_access ? waits_left : int'($urandom_range(max_waits, 0));
            in_access  <= 1'b1;
            waits_left <= (waits > 0) ? waits - 1 : 0;
            pready     <= (waits == 0);
            prdata     <= paddr ^ read_xor;
            if (waits == 0 && pwrite) begin
                $display("%0t: apb write %h <= %h", $time, paddr, pwdata);
            end
        end
    end

    task automatic compare_transfer();
        compared++;
        if (prev_pwrite) begin
            assert (exp_wr_addr.size() > 0) else begin
                report_failure($sformatf("APB write to %h that the model does not predict",
                                         prev_paddr));
            end
            if (exp_wr_addr.size() > 0) begin
                assert (prev_paddr == exp_wr_addr[0])
                    else report_value("paddr", exp_wr_addr[0], prev_paddr);
                assert (prev_pwdata == exp_wr_data[0])
                    else report_value("pwdata", exp_wr_data[0], prev_pwdata);
                void'(exp_wr_addr.pop_front());
                void'(exp_wr_data.pop_front());
            end
        end else begin
            assert (exp_rd_addr.size() > 0) else begin
                report_failure($sformatf("APB read from %h that the model does not predict",
                                         prev_paddr));
            end
            if (exp_rd_addr.size() > 0) begin
                assert (prev_paddr == exp_rd_addr[0])
                    else report_value("paddr", exp_rd_addr[0], prev_paddr);
                void'(exp_rd_addr.pop_front());
            end
        end
    endtask

    // pready still holds the value the last posedge saw
    always @(negedge clk) begin : apb_checker
        logic done;
        if (reset) begin
            prev_psel    = 1'b0;
            prev_penable = 1'b0;
            prev_pwrite  = 1'b0;
            prev_halted  = 1'b0;
            seen         = 0;
            since_done   = 0;
        end else begin
            done = prev_psel && prev_penable && pready;
            assert (psel || !penable) else report_failure("penable high while psel is low");
            if (psel && !prev_psel) begin
                assert (!penable) else report_failure("APB transfer began without setup cycle");
            end
            // after a setup or wait cycle the transfer goes on unchanged
            if (prev_psel && !(prev_penable && pready)) begin
                assert (psel && penable) else report_failure("psel or penable dropped early");
                assert (paddr == prev_paddr && pwrite == prev_pwrite && pwdata == prev_pwdata)
                    else report_failure("paddr, pwrite or pwdata changed during a transfer");
            end
            if (done) begin
                assert (!psel && !penable)
                    else report_failure("psel or penable still high after the transfer");
                compare_transfer();
                seen++;
                since_done = 0;
            end else begin
                since_done++;
            end
            if (halted) begin
                assert (!psel) else report_failure("APB transfer after halt");
            end
            if (halted && !prev_halted) begin
                assert (since_done <= 3) else begin
                    report_failure($sformatf("halted rose %0d cycles after the last transfer",
                                             since_done));
                end
                assert (seen == exp_total)
                    else report_value("transfer count", word_t'(exp_total), word_t'(seen));
            end
            prev_psel    = psel;
            prev_penable = penable;
            prev_pwrite  = pwrite;
            prev_paddr   = paddr;
            prev_pwdata  = pwdata;
            prev_halted  = halted;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            print_counts();
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(43520));
        reset       = 1'b1;
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_data   = '0;
        cycle_limit = cycles_per_op;
        build_arith_program(1'b1);
        load_program();
        wait_for_halt();
        build_bitwise_program();
        load_program();
        wait_for_halt();
        build_scratch_program();
        load_program();
        wait_for_halt();
        build_apb_load_program();
        load_program();
        wait_for_halt();
        // interrupted run and a reload that starts from zeroed registers
        build_arith_program(1'b1);
        load_program();
        reset_mid_program();
        build_arith_program(1'b0);
        load_program();
        wait_for_halt();
        print_counts();
        if (data_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
logic/vm16_pkg.sv
logic/vm16_decoder.sv
logic/vm16_alu.sv
logic/vm16_regfile.sv
logic/vm16_bram.sv
logic/vm16_mmu.sv
logic/vm16_core.sv
+incdir+tb
tb/tb_vm16_core.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_vm16_core \
    -f files.f -o vm16_sim > build.log 2>&1 \
    && ./obj_dir/vm16_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qx "Test OK" sim.log && exit 0 || exit 1
